//--- source/axil2apb_pkg.sv
package axil2apb_pkg;

	////////////////////
	// Bus widths
	////////////////////
	parameter int ADDR_WIDTH = 32;
	parameter int DATA_WIDTH = 32;
	parameter int STRB_WIDTH = DATA_WIDTH / 8;
	// Byte select bits within one data word
	parameter int ADDR_LSB = 2;
	parameter int WADDR_WIDTH = ADDR_WIDTH - ADDR_LSB;

	////////////////////
	// Vector types
	////////////////////
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [WADDR_WIDTH-1:0] waddr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [STRB_WIDTH-1:0] strb_t;
	typedef logic [2:0] prot_t;
	typedef logic [1:0] resp_t;

	// AXI response codes
	parameter resp_t RESP_OKAY = 2'b00;
	parameter resp_t RESP_SLVERR = 2'b10;

	// APB phases
	typedef enum logic [1:0]
	{
		APB_IDLE = 2'b00,
		APB_SETUP = 2'b01,
		APB_ACCESS = 2'b10
	} apb_phase_e;

endpackage

//--- source/skid_buffer.sv
`timescale 1ns/1ps

module skid_buffer #(
	parameter int DW = 8
) (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Upstream side
	input logic i_valid,
	input logic [DW-1:0] i_data,
	output logic o_ready,
	// Downstream side
	output logic o_valid,
	output logic [DW-1:0] o_data,
	input logic i_ready
);

	// Holding register occupancy
	logic r_valid;
	// Holding register contents
	logic [DW-1:0] r_data;

	////////////////////
	// Occupancy
	////////////////////

	// Capture when an item arrives and downstream stalls
	// Drain as soon as downstream accepts
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			r_valid <= 1'b0;
		else if (i_valid && o_ready && !i_ready)
			r_valid <= 1'b1;
		else if (i_ready)
			r_valid <= 1'b0;
	end

	// Upstream ready comes straight from a flop
	// So it never sees downstream ready in the same cycle
	assign o_ready = !r_valid;

	////////////////////
	// Payload
	////////////////////

	// Track input while empty
	// Freeze once full, the stored item goes out first
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (o_ready)
			r_data <= i_data;
	end

	////////////////////
	// Downstream view
	////////////////////

	// Pass-through when empty
	assign o_valid = i_valid || r_valid;

	// Stored item has priority over new input
	always_comb
	begin
		if (r_valid)
			o_data = r_data;
		else
			o_data = i_data;
	end

endmodule

//--- source/axil_arbiter.sv
`timescale 1ns/1ps

module axil_arbiter (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Skid buffer outputs
	input logic i_aw_valid,
	input logic i_w_valid,
	input logic i_ar_valid,
	// APB side free to start
	input logic i_apb_idle,
	// Return channels held by back-pressure
	input logic i_b_blocked,
	input logic i_r_blocked,
	// Grants, at most one per cycle
	output logic o_write_go,
	output logic o_read_go
);

	// Write needs both address and data
	logic write_req;
	// Set when writes win the next contest
	logic write_grant;

	assign write_req = i_aw_valid && i_w_valid;

	////////////////////
	// Write go
	////////////////////
	always_comb
	begin
		o_write_go = i_apb_idle;
		// Nowhere to put the response yet
		if (i_b_blocked)
			o_write_go = 1'b0;
		// Incomplete write request
		if (!write_req)
			o_write_go = 1'b0;
		// Read waiting and it is the read's turn
		if (i_ar_valid && !write_grant)
			o_write_go = 1'b0;
	end

	////////////////////
	// Read go
	////////////////////
	always_comb
	begin
		o_read_go = i_apb_idle;
		if (i_r_blocked)
			o_read_go = 1'b0;
		if (!i_ar_valid)
			o_read_go = 1'b0;
		// Write waiting and it is the write's turn
		if (write_req && write_grant)
			o_read_go = 1'b0;
	end

	////////////////////
	// Alternation
	////////////////////

	// Turn passes to the other direction after every go
	// Writes get the first turn out of reset
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			write_grant <= 1'b1;
		else if (o_write_go)
			write_grant <= 1'b0;
		else if (o_read_go)
			write_grant <= 1'b1;
	end

endmodule

//--- source/apb_master.sv
`timescale 1ns/1ps

module apb_master (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Grants from the arbiter
	input logic i_write_go,
	input logic i_read_go,
	// Write request payload
	input axil2apb_pkg::waddr_t i_aw_addr,
	input axil2apb_pkg::prot_t i_aw_prot,
	input axil2apb_pkg::data_t i_w_data,
	input axil2apb_pkg::strb_t i_w_strb,
	// Read request payload
	input axil2apb_pkg::waddr_t i_ar_addr,
	input axil2apb_pkg::prot_t i_ar_prot,
	// Status toward arbiter and response stage
	output logic o_apb_idle,
	output logic o_done_write,
	output logic o_done_read,
	// APB master
	output logic o_m_apb_psel,
	output logic o_m_apb_penable,
	output axil2apb_pkg::addr_t o_m_apb_paddr,
	output logic o_m_apb_pwrite,
	output axil2apb_pkg::data_t o_m_apb_pwdata,
	output axil2apb_pkg::strb_t o_m_apb_pwstrb,
	output axil2apb_pkg::prot_t o_m_apb_pprot,
	input logic i_m_apb_pready
);

	axil2apb_pkg::apb_phase_e state;
	axil2apb_pkg::apb_phase_e next_state;
	// Completion edge of the access phase
	logic xfer_end;

	////////////////////
	// Phase FSM
	////////////////////
	always_comb
	begin
		next_state = state;
		case (state)
			axil2apb_pkg::APB_IDLE:
			begin
				if (i_write_go || i_read_go)
					next_state = axil2apb_pkg::APB_SETUP;
			end
			// Setup always lasts one cycle
			axil2apb_pkg::APB_SETUP:
				next_state = axil2apb_pkg::APB_ACCESS;
			// Stay until the slave is ready
			axil2apb_pkg::APB_ACCESS:
			begin
				if (i_m_apb_pready)
					next_state = axil2apb_pkg::APB_IDLE;
			end
			default:
				next_state = axil2apb_pkg::APB_IDLE;
		endcase
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			state <= axil2apb_pkg::APB_IDLE;
		else
			state <= next_state;
	end

	////////////////////
	// Request capture
	////////////////////

	// Latched once per transfer, read has no strobes
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (state == axil2apb_pkg::APB_IDLE)
		begin
			if (i_read_go)
			begin
				o_m_apb_paddr <= {i_ar_addr, {axil2apb_pkg::ADDR_LSB{1'b0}}};
				o_m_apb_pprot <= i_ar_prot;
				o_m_apb_pwrite <= 1'b0;
				o_m_apb_pwstrb <= '0;
			end
			else if (i_write_go)
			begin
				o_m_apb_paddr <= {i_aw_addr, {axil2apb_pkg::ADDR_LSB{1'b0}}};
				o_m_apb_pprot <= i_aw_prot;
				o_m_apb_pwrite <= 1'b1;
				o_m_apb_pwdata <= i_w_data;
				o_m_apb_pwstrb <= i_w_strb;
			end
		end
	end

	// Bus control straight from the phase
	assign o_m_apb_psel = (state != axil2apb_pkg::APB_IDLE);
	assign o_m_apb_penable = (state == axil2apb_pkg::APB_ACCESS);
	assign o_apb_idle = (state == axil2apb_pkg::APB_IDLE);

	// One cycle pulse on the edge that samples PREADY
	assign xfer_end = (state == axil2apb_pkg::APB_ACCESS) && i_m_apb_pready;
	assign o_done_write = xfer_end && o_m_apb_pwrite;
	assign o_done_read = xfer_end && !o_m_apb_pwrite;

endmodule

//--- source/axil_response.sv
`timescale 1ns/1ps

module axil_response (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// Completion from the APB side
	input logic i_done_write,
	input logic i_done_read,
	input axil2apb_pkg::data_t i_m_apb_prdata,
	input logic i_m_apb_pslverr,
	// Write response channel
	output logic o_s_axi_bvalid,
	input logic i_s_axi_bready,
	output axil2apb_pkg::resp_t o_s_axi_bresp,
	// Read data channel
	output logic o_s_axi_rvalid,
	input logic i_s_axi_rready,
	output axil2apb_pkg::resp_t o_s_axi_rresp,
	output axil2apb_pkg::data_t o_s_axi_rdata,
	// Back-pressure status to the arbiter
	output logic o_b_blocked,
	output logic o_r_blocked
);

	// APB error mapped onto an AXI code
	axil2apb_pkg::resp_t done_resp;

	assign done_resp = i_m_apb_pslverr ? axil2apb_pkg::RESP_SLVERR
		: axil2apb_pkg::RESP_OKAY;

	////////////////////
	// B channel
	////////////////////

	// Load when empty or draining, else hold
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_s_axi_bvalid <= 1'b0;
		else if (!o_s_axi_bvalid || i_s_axi_bready)
			o_s_axi_bvalid <= i_done_write;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if ((!o_s_axi_bvalid || i_s_axi_bready) && i_done_write)
			o_s_axi_bresp <= done_resp;
	end

	////////////////////
	// R channel
	////////////////////
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_s_axi_rvalid <= 1'b0;
		else if (!o_s_axi_rvalid || i_s_axi_rready)
			o_s_axi_rvalid <= i_done_read;
	end

	// PRDATA is only meaningful on a read completion
	always_ff @(posedge S_AXI_ACLK)
	begin
		if ((!o_s_axi_rvalid || i_s_axi_rready) && i_done_read)
		begin
			o_s_axi_rresp <= done_resp;
			o_s_axi_rdata <= i_m_apb_prdata;
		end
	end

	// Response sitting unaccepted
	assign o_b_blocked = o_s_axi_bvalid && !i_s_axi_bready;
	assign o_r_blocked = o_s_axi_rvalid && !i_s_axi_rready;

endmodule

//--- source/axil2apb_top.sv
`timescale 1ns/1ps

module axil2apb_top (
	input logic S_AXI_ACLK,
	input logic S_AXI_ARESETN,
	// AXI-lite write address
	input logic i_s_axi_awvalid,
	output logic o_s_axi_awready,
	input axil2apb_pkg::addr_t i_s_axi_awaddr,
	input axil2apb_pkg::prot_t i_s_axi_awprot,
	// AXI-lite write data
	input logic i_s_axi_wvalid,
	output logic o_s_axi_wready,
	input axil2apb_pkg::data_t i_s_axi_wdata,
	input axil2apb_pkg::strb_t i_s_axi_wstrb,
	// AXI-lite write response
	output logic o_s_axi_bvalid,
	input logic i_s_axi_bready,
	output axil2apb_pkg::resp_t o_s_axi_bresp,
	// AXI-lite read address
	input logic i_s_axi_arvalid,
	output logic o_s_axi_arready,
	input axil2apb_pkg::addr_t i_s_axi_araddr,
	input axil2apb_pkg::prot_t i_s_axi_arprot,
	// AXI-lite read data
	output logic o_s_axi_rvalid,
	input logic i_s_axi_rready,
	output axil2apb_pkg::data_t o_s_axi_rdata,
	output axil2apb_pkg::resp_t o_s_axi_rresp,
	// APB master
	output logic o_m_apb_psel,
	output logic o_m_apb_penable,
	output axil2apb_pkg::addr_t o_m_apb_paddr,
	output logic o_m_apb_pwrite,
	output axil2apb_pkg::data_t o_m_apb_pwdata,
	output axil2apb_pkg::strb_t o_m_apb_pwstrb,
	output axil2apb_pkg::prot_t o_m_apb_pprot,
	input logic i_m_apb_pready,
	input axil2apb_pkg::data_t i_m_apb_prdata,
	input logic i_m_apb_pslverr
);

	// Word address plus prot
	localparam int ADDR_DW = axil2apb_pkg::WADDR_WIDTH + $bits(axil2apb_pkg::prot_t);
	// Data plus strobes
	localparam int WDATA_DW = axil2apb_pkg::DATA_WIDTH + axil2apb_pkg::STRB_WIDTH;

	logic aw_valid, w_valid, ar_valid;
	logic write_go, read_go;
	logic apb_idle, done_write, done_read;
	logic b_blocked, r_blocked;
	logic [ADDR_DW-1:0] aw_skid_data, ar_skid_data;
	logic [WDATA_DW-1:0] w_skid_data;

	////////////////////
	// Front end
	////////////////////

	// Byte lane bits dropped here, APB side is word aligned
	skid_buffer #(.DW(ADDR_DW)) aw_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_s_axi_awvalid), .o_ready(o_s_axi_awready),
		.i_data({i_s_axi_awaddr[axil2apb_pkg::ADDR_WIDTH-1:axil2apb_pkg::ADDR_LSB],
			i_s_axi_awprot}),
		.o_valid(aw_valid), .o_data(aw_skid_data), .i_ready(write_go));

	skid_buffer #(.DW(WDATA_DW)) w_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_s_axi_wvalid), .o_ready(o_s_axi_wready),
		.i_data({i_s_axi_wdata, i_s_axi_wstrb}),
		.o_valid(w_valid), .o_data(w_skid_data), .i_ready(write_go));

	skid_buffer #(.DW(ADDR_DW)) ar_skid (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_valid(i_s_axi_arvalid), .o_ready(o_s_axi_arready),
		.i_data({i_s_axi_araddr[axil2apb_pkg::ADDR_WIDTH-1:axil2apb_pkg::ADDR_LSB],
			i_s_axi_arprot}),
		.o_valid(ar_valid), .o_data(ar_skid_data), .i_ready(read_go));

	////////////////////
	// Control
	////////////////////
	axil_arbiter u_arbiter (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_aw_valid(aw_valid), .i_w_valid(w_valid), .i_ar_valid(ar_valid),
		.i_apb_idle(apb_idle), .i_b_blocked(b_blocked), .i_r_blocked(r_blocked),
		.o_write_go(write_go), .o_read_go(read_go));

	// Skid buffer words split back into fields
	apb_master u_apb_master (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_write_go(write_go), .i_read_go(read_go),
		.i_aw_addr(aw_skid_data[ADDR_DW-1:3]), .i_aw_prot(aw_skid_data[2:0]),
		.i_w_data(w_skid_data[WDATA_DW-1:axil2apb_pkg::STRB_WIDTH]),
		.i_w_strb(w_skid_data[axil2apb_pkg::STRB_WIDTH-1:0]),
		.i_ar_addr(ar_skid_data[ADDR_DW-1:3]), .i_ar_prot(ar_skid_data[2:0]),
		.o_apb_idle(apb_idle), .o_done_write(done_write), .o_done_read(done_read),
		.o_m_apb_psel(o_m_apb_psel), .o_m_apb_penable(o_m_apb_penable),
		.o_m_apb_paddr(o_m_apb_paddr), .o_m_apb_pwrite(o_m_apb_pwrite),
		.o_m_apb_pwdata(o_m_apb_pwdata), .o_m_apb_pwstrb(o_m_apb_pwstrb),
		.o_m_apb_pprot(o_m_apb_pprot), .i_m_apb_pready(i_m_apb_pready));

	axil_response u_response (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_done_write(done_write), .i_done_read(done_read),
		.i_m_apb_prdata(i_m_apb_prdata), .i_m_apb_pslverr(i_m_apb_pslverr),
		.o_s_axi_bvalid(o_s_axi_bvalid), .i_s_axi_bready(i_s_axi_bready),
		.o_s_axi_bresp(o_s_axi_bresp),
		.o_s_axi_rvalid(o_s_axi_rvalid), .i_s_axi_rready(i_s_axi_rready),
		.o_s_axi_rresp(o_s_axi_rresp), .o_s_axi_rdata(o_s_axi_rdata),
		.o_b_blocked(b_blocked), .o_r_blocked(r_blocked));

endmodule

//--- verif/tb_axil2apb.sv
`timescale 1ns/1ps

module tb_axil2apb;

	logic S_AXI_ACLK;
	logic S_AXI_ARESETN;
	// AXI-lite side
	logic awvalid;
	logic awready;
	axil2apb_pkg::addr_t awaddr;
	logic [2:0] awprot;
	logic wvalid;
	logic wready;
	axil2apb_pkg::data_t wdata;
	logic [3:0] wstrb;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	axil2apb_pkg::addr_t araddr;
	logic [2:0] arprot;
	logic rvalid;
	logic rready;
	axil2apb_pkg::data_t rdata;
	logic [1:0] rresp;
	// APB side
	logic psel;
	logic penable;
	axil2apb_pkg::addr_t paddr;
	logic pwrite;
	axil2apb_pkg::data_t pwdata;
	logic [3:0] pwstrb;
	logic [2:0] pprot;
	logic pready;
	axil2apb_pkg::data_t prdata;
	logic pslverr;

	// APB slave memory of 16 words
	axil2apb_pkg::data_t mem [16];
	integer seed = 23;
	int cycles = 0;
	int cycle_limit = 0;
	int apb_wait = 0;
	// Direction of each APB transfer with 1 for write
	bit apb_log[$];
	// Expected responses per channel in issue order
	logic [1:0] b_exp[$];
	logic [1:0] r_exp_resp[$];
	axil2apb_pkg::data_t r_exp_data[$];
	// Request in flight as seen by the APB model
	axil2apb_pkg::addr_t cur_w_addr;
	axil2apb_pkg::addr_t cur_r_addr;
	axil2apb_pkg::data_t cur_w_data;
	logic [3:0] cur_w_strb;
	// Vector table
	byte v_op[$];
	axil2apb_pkg::addr_t v_addr[$];
	axil2apb_pkg::data_t v_wdata[$];
	logic [3:0] v_strb[$];
	axil2apb_pkg::addr_t v_addr2[$];
	axil2apb_pkg::data_t v_exp[$];
	logic [1:0] v_resp[$];

	axil2apb_top uut (
		.S_AXI_ACLK(S_AXI_ACLK), .S_AXI_ARESETN(S_AXI_ARESETN),
		.i_s_axi_awvalid(awvalid), .o_s_axi_awready(awready),
		.i_s_axi_awaddr(awaddr), .i_s_axi_awprot(awprot),
		.i_s_axi_wvalid(wvalid), .o_s_axi_wready(wready),
		.i_s_axi_wdata(wdata), .i_s_axi_wstrb(wstrb),
		.o_s_axi_bvalid(bvalid), .i_s_axi_bready(bready), .o_s_axi_bresp(bresp),
		.i_s_axi_arvalid(arvalid), .o_s_axi_arready(arready),
		.i_s_axi_araddr(araddr), .i_s_axi_arprot(arprot),
		.o_s_axi_rvalid(rvalid), .i_s_axi_rready(rready),
		.o_s_axi_rdata(rdata), .o_s_axi_rresp(rresp),
		.o_m_apb_psel(psel), .o_m_apb_penable(penable), .o_m_apb_paddr(paddr),
		.o_m_apb_pwrite(pwrite), .o_m_apb_pwdata(pwdata), .o_m_apb_pwstrb(pwstrb),
		.o_m_apb_pprot(pprot), .i_m_apb_pready(pready),
		.i_m_apb_prdata(prdata), .i_m_apb_pslverr(pslverr));

	////////////////////
	// Helpers
	////////////////////
	task automatic stop_on_failure(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1, "Stopped at first failure");
	endtask

	task automatic value_error(input string what);
		stop_on_failure($sformatf("[ERROR] %0t: %s", $time, what));
	endtask

	// Byte-lane write rule of APB strobes
	function automatic axil2apb_pkg::data_t merge_bytes(input axil2apb_pkg::data_t old_word,
		input axil2apb_pkg::data_t new_word, input logic [3:0] strb);
		axil2apb_pkg::data_t result;
		int k;
		result = old_word;
		for (k = 0; k < 4; k++)
		begin
			if (strb[k])
				result[8*k +: 8] = new_word[8*k +: 8];
		end
		return result;
	endfunction

	// Each request holds valid until its handshake edge
	task automatic send_aw(input axil2apb_pkg::addr_t addr);
		awvalid = 1'b1;
		awaddr = addr;
		awprot = 3'b001;
		@(posedge S_AXI_ACLK);
		while (!awready)
			@(posedge S_AXI_ACLK);
		#1;
		awvalid = 1'b0;
	endtask

	task automatic send_w(input axil2apb_pkg::data_t data, input logic [3:0] strb);
		wvalid = 1'b1;
		wdata = data;
		wstrb = strb;
		@(posedge S_AXI_ACLK);
		while (!wready)
			@(posedge S_AXI_ACLK);
		#1;
		wvalid = 1'b0;
	endtask

	task automatic send_ar(input axil2apb_pkg::addr_t addr);
		arvalid = 1'b1;
		araddr = addr;
		arprot = 3'b010;
		@(posedge S_AXI_ACLK);
		while (!arready)
			@(posedge S_AXI_ACLK);
		#1;
		arvalid = 1'b0;
	endtask

	// Returns 1 ns after the edge that drained the last response
	task automatic wait_responses();
		while (b_exp.size() != 0 || r_exp_resp.size() != 0)
		begin
			@(posedge S_AXI_ACLK);
			#1;
		end
	endtask

	////////////////////
	// Clock and timeout
	////////////////////
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever #5 S_AXI_ACLK = ~S_AXI_ACLK;
	end

	always @(posedge S_AXI_ACLK)
	begin
		cycles = cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit)
			stop_on_failure("Timeout: the run went past its cycle limit");
	end

	// Random back-pressure on B and R
	always @(posedge S_AXI_ACLK)
	begin
		#1;
		bready = ($random(seed) & 3) != 0;
		rready = ($random(seed) & 3) != 0;
	end

	////////////////////
	// APB slave model
	////////////////////
	always @(posedge S_AXI_ACLK)
	begin : apb_slave
		logic next_ready;
		logic load;
		logic next_err;
		axil2apb_pkg::data_t next_data;
		next_ready = 1'b0;
		load = 1'b0;
		next_err = 1'b0;
		next_data = '0;
		// Write lands on the completion edge
		if (psel && penable && pready && pwrite && paddr[31:6] == '0)
			mem[paddr[5:2]] = merge_bytes(mem[paddr[5:2]], pwdata, pwstrb);
		if (psel && !penable)
		begin
			assert (paddr[1:0] == 2'b00)
			else value_error($sformatf("PADDR %h not word aligned", paddr));
			apb_log.push_back(pwrite);
			if (pwrite)
			begin
				assert (paddr == {cur_w_addr[31:2], 2'b00} && pwdata == cur_w_data
					&& pwstrb == cur_w_strb && pprot == 3'b001)
				else value_error($sformatf("APB write %h %h %h, expected %h %h %h",
					paddr, pwdata, pwstrb, cur_w_addr, cur_w_data, cur_w_strb));
			end
			else
			begin
				assert (paddr == {cur_r_addr[31:2], 2'b00} && pprot == 3'b010)
				else value_error($sformatf("APB read at %h, expected %h", paddr, cur_r_addr));
			end
			// Zero to two wait states
			apb_wait = $unsigned($random(seed)) % 3;
			next_ready = (apb_wait == 0);
			load = 1'b1;
			next_err = (paddr[31:6] != '0);
			next_data = next_err ? '0 : mem[paddr[5:2]];
		end
		else if (psel && penable && !pready)
		begin
			apb_wait = apb_wait - 1;
			next_ready = (apb_wait == 0);
		end
		#1;
		pready = next_ready;
		if (load)
		begin
			pslverr = next_err;
			prdata = next_data;
		end
	end

	////////////////////
	// Response monitor
	////////////////////
	always @(posedge S_AXI_ACLK)
	begin
		if (S_AXI_ARESETN && bvalid && bready)
		begin
			assert (b_exp.size() > 0)
			else value_error("B response with no write outstanding");
			assert (bresp == b_exp[0])
			else value_error($sformatf("BRESP %0d, expected %0d", bresp, b_exp[0]));
			b_exp.delete(0);
		end
		if (S_AXI_ARESETN && rvalid && rready)
		begin
			assert (r_exp_resp.size() > 0)
			else value_error("R response with no read outstanding");
			assert (rresp == r_exp_resp[0])
			else value_error($sformatf("RRESP %0d, expected %0d", rresp, r_exp_resp[0]));
			// Data only defined on a clean read
			if (r_exp_resp[0] == axil2apb_pkg::RESP_OKAY)
			begin
				assert (rdata == r_exp_data[0])
				else value_error($sformatf("RDATA %h, expected %h", rdata, r_exp_data[0]));
			end
			r_exp_resp.delete(0);
			r_exp_data.delete(0);
		end
	end

	////////////////////
	// Main sequence
	////////////////////
	initial
	begin : main
		int fd;
		int n;
		int i;
		int log_start;
		string line;
		logic [31:0] f_addr;
		logic [31:0] f_wdata;
		logic [31:0] f_strb;
		logic [31:0] f_addr2;
		logic [31:0] f_exp;
		logic [31:0] f_resp;
		logic do_write;
		logic do_read;
		logic w_in_range;
		axil2apb_pkg::data_t want_word;
		S_AXI_ARESETN = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		awprot = '0;
		wvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		arvalid = 1'b0;
		araddr = '0;
		arprot = '0;
		bready = 1'b0;
		rready = 1'b0;
		pready = 1'b0;
		prdata = '0;
		pslverr = 1'b0;
		for (i = 0; i < 16; i++)
			mem[i] = 32'hC0DE_0000 + i;
		// Vector table where comment lines start with #
		fd = $fopen("verif/axil2apb_vectors.txt", "r");
		if (fd == 0)
			stop_on_failure("Could not open verif/axil2apb_vectors.txt");
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#")
			begin
				n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
					f_addr, f_wdata, f_strb, f_addr2, f_exp, f_resp);
				if (n != 6)
					stop_on_failure("Malformed line in the vector file");
				v_op.push_back(line[0]);
				v_addr.push_back(f_addr);
				v_wdata.push_back(f_wdata);
				v_strb.push_back(f_strb[3:0]);
				v_addr2.push_back(f_addr2);
				v_exp.push_back(f_exp);
				v_resp.push_back(f_resp[1:0]);
			end
		end
		$fclose(fd);
		cycle_limit = 40 * v_op.size() + 100;

		// Three reset cycles then the idle state check
		repeat (3) @(posedge S_AXI_ACLK);
		#1;
		S_AXI_ARESETN = 1'b1;
		@(posedge S_AXI_ACLK);
		assert (!psel && !penable && !bvalid && !rvalid)
		else value_error("PSEL, PENABLE, BVALID or RVALID high after reset");
		assert (awready && wready && arready)
		else value_error("Skid buffer not empty after reset");
		#1;

		for (i = 0; i < v_op.size(); i++)
		begin
			log_start = apb_log.size();
			do_write = (v_op[i] == "W" || v_op[i] == "P");
			do_read = (v_op[i] == "R" || v_op[i] == "P");
			w_in_range = (v_addr[i][31:6] == '0);
			if (do_write)
			begin
				cur_w_addr = v_addr[i];
				cur_w_data = v_wdata[i];
				cur_w_strb = v_strb[i];
				// Model memory before the write
				want_word = merge_bytes(mem[v_addr[i][5:2]], v_wdata[i], v_strb[i]);
				b_exp.push_back(v_resp[i]);
			end
			if (do_read)
			begin
				cur_r_addr = (v_op[i] == "P") ? v_addr2[i] : v_addr[i];
				r_exp_resp.push_back(v_resp[i]);
				r_exp_data.push_back(v_exp[i]);
			end
			fork
				if (do_write) send_aw(cur_w_addr);
				if (do_write) send_w(cur_w_data, cur_w_strb);
				if (do_read) send_ar(cur_r_addr);
			join
			wait_responses();
			if (do_write && w_in_range)
			begin
				assert (mem[v_addr[i][5:2]] == want_word)
				else value_error($sformatf("Memory word %h, expected %h",
					mem[v_addr[i][5:2]], want_word));
			end
			// Contention goes to the direction opposite the last transfer
			if (v_op[i] == "P")
			begin
				assert (apb_log.size() == log_start + 2
					&& apb_log[log_start] != apb_log[log_start + 1]
					&& (log_start == 0 || apb_log[log_start] != apb_log[log_start - 1]))
				else value_error($sformatf("APB order wrong for parallel vector %0d", i));
			end
		end

		// Idle cycles so that a duplicate response reaches the monitor
		repeat (8) @(posedge S_AXI_ACLK);
		#1;
		if (!bvalid && !rvalid && !psel)
		begin
			$display("Regression passed");
			$finish;
		end
		else
			stop_on_failure("A response or an APB transfer was still active after the last vector");
	end

endmodule

//--- build.f
source/axil2apb_pkg.sv
source/skid_buffer.sv
source/axil_arbiter.sv
source/apb_master.sv
source/axil_response.sv
source/axil2apb_top.sv
verif/tb_axil2apb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass message in the output
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_axil2apb -f build.f -o tb_axil2apb \
	&& ./obj_dir/tb_axil2apb | tee /dev/stderr | grep -q "Regression passed" \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }

//--- verif/axil2apb_vectors.txt
# op addr wdata strb addr2 expdata expresp (hex; op W write, R read, P write and read together)
# W uses addr/wdata/strb, R uses addr, P reads addr2; expdata is the read data, expresp covers B and R
W 00000000 11223344 f 00000000 00000000 0
R 00000000 00000000 0 00000000 11223344 0
W 00000004 a1b2c3d4 f 00000000 00000000 0
R 00000007 00000000 0 00000000 a1b2c3d4 0
W 00000008 deadbeef 3 00000000 00000000 0
R 00000008 00000000 0 00000000 c0debeef 0
W 0000000c 55667788 c 00000000 00000000 0
R 0000000e 00000000 0 00000000 55660003 0
W 00000010 cafef00d 5 00000000 00000000 0
R 00000010 00000000 0 00000000 c0fe000d 0
W 00000040 12345678 f 00000000 00000000 2
R 00000044 00000000 0 00000000 00000000 2
R 00000100 00000000 0 00000000 00000000 2
R 0000001c 00000000 0 00000000 c0de0007 0
P 00000014 0badf00d f 00000000 11223344 0
P 00000018 76543210 f 00000014 0badf00d 0
R 00000018 00000000 0 00000000 76543210 0
P 00000004 ffeeddcc 2 0000000c 55660003 0
R 00000004 00000000 0 00000000 a1b2ddd4 0
W 0000003c 89abcdef f 00000000 00000000 0
R 0000003c 00000000 0 00000000 89abcdef 0
P 00000080 00000001 f 00000084 00000000 2
